// ==== verilog/console_pkg.sv ====
/*
 * Shared types and constants of the console housekeeping logic
 *   Byte, download address and ROM address types
 *   Cheat record, seen as 16 bytes or as four 32-bit fields
 *   Clock-enable phase sets, cartridge header size, download indexes
 */
`default_nettype none

package console_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;  // Host download address
	typedef logic [21:0] rom_addr_t; // Cartridge byte address

	// ==========================================================
	// Cheat record
	// ==========================================================
	// Fields are little-endian, byte offset 0 is the low flags byte
	typedef struct packed {
		logic [31:0] replace; // Offsets 12..15
		logic [31:0] compare; // Offsets 8..11
		logic [31:0] addr;    // Offsets 4..7
		logic [31:0] flags;   // Offsets 0..3
	} cheat_rec_t;

	typedef union packed {
		byte_t [15:0] b;      // Loader view, one byte per offset
		cheat_rec_t   rec;    // Core view
	} cheat_code_u;

	// ==========================================================
	// Clock-enable divider
	// ==========================================================
	localparam int CE_PHASES = 30;

	// One bit per phase, set where the enable is raised
	localparam logic [CE_PHASES-1:0] CE_CPU_PHASES = (30'd1 << 9) | (30'd1 << 24);
	localparam logic [CE_PHASES-1:0] CE_PIX_PHASES =
		(30'd1 << 9) | (30'd1 << 19) | (30'd1 << 29);

	// Download and cartridge constants
	localparam int          HEADER_BYTES = 512;    // Optional header in front of the ROM
	localparam logic [7:0]  CHEAT_INDEX  = 8'hFF;  // Cheat file download
	localparam logic [4:0]  GG_INDEX     = 5'd2;   // Handheld cartridge

endpackage

`default_nettype wire

// ==== verilog/ce_divider.sv ====
/*
 * Clock-enable divider
 *   30-phase counter on the system clock
 *   Registered CPU, video-processor, pixel and sprite enables
 */
`default_nettype none

module ce_divider (
	input  wire  clk_sys,
	input  wire  arst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	localparam int PW = $clog2(console_pkg::CE_PHASES);

	logic [PW-1:0] phase;

	// Phase counter, wraps at the end of the cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			phase <= '0;
		end else if (phase == PW'(console_pkg::CE_PHASES - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// ==========================================================
	// Enable decode, one cycle behind the phase
	// ==========================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			ce_cpu <= console_pkg::CE_CPU_PHASES[phase]; // Divide by 15
			ce_pix <= console_pkg::CE_PIX_PHASES[phase]; // Divide by 10
			ce_vdp <= (phase % 5) == 4;                  // Divide by 5
			ce_sp  <= phase[0];                          // Every other cycle
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cart_loader.sv ====
/*
 * Cartridge loader
 *   ROM write toggle handshake with download back-pressure
 *   Address mask and header learning per download
 *   Combinational ROM read address translation
 */
`default_nettype none

module cart_loader #(
	parameter int ROM_AW = 22
) (
	input  wire                    clk_sys,
	input  wire                    arst_n,
	input  wire                    ioctl_download,
	input  console_pkg::byte_t     ioctl_index,
	input  wire                    ioctl_wr,
	input  console_pkg::dl_addr_t  ioctl_addr,
	input  console_pkg::byte_t     ioctl_dout,
	output logic                   ioctl_wait,
	output logic                   rom_wr,
	input  wire                    rom_wr_ack,
	output console_pkg::rom_addr_t rom_waddr,
	output console_pkg::byte_t     rom_wdata,
	input  console_pkg::rom_addr_t rom_raddr_in,
	output console_pkg::rom_addr_t rom_raddr,
	output logic                   gg_mode
);

	logic              cart_dl, cart_dl_q;
	logic              cart_wr;
	logic [ROM_AW-1:0] waddr;
	logic [ROM_AW-1:0] mask, mask512;
	logic              has_hdr;

	assign cart_dl = ioctl_download && (ioctl_index != console_pkg::CHEAT_INDEX);
	assign cart_wr = ioctl_wr && cart_dl;

	// ==========================================================
	// Write handshake
	// ==========================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_dl_q  <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr     <= 1'b0;
			waddr      <= '0;
			gg_mode    <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_wr) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;     // New request for the memory
				gg_mode    <= ioctl_index[4:0] == console_pkg::GG_INDEX;
			end else if (ioctl_wait && (rom_wr == rom_wr_ack)) begin
				ioctl_wait <= 1'b0;        // Memory caught up
				waddr      <= waddr + 1'b1;
			end
			if (cart_dl && !cart_dl_q)
				waddr <= '0;               // New cartridge starts at 0
		end
	end

	// Learned cartridge geometry and write data
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_wdata <= ioctl_dout;
			if (ioctl_addr == '0)
				mask <= '0;
			else
				mask <= mask | ioctl_addr[ROM_AW-1:0];
			// Same mask as if the header were not there
			if (ioctl_addr == console_pkg::dl_addr_t'(console_pkg::HEADER_BYTES))
				mask512 <= '0;
			else
				mask512 <= mask512 |
					(ioctl_addr[ROM_AW-1:0] - ROM_AW'(console_pkg::HEADER_BYTES));
		end
		if (cart_dl_q && !cart_dl)
			has_hdr <= ioctl_addr[9];      // Odd 512-byte count
	end

	assign rom_waddr = waddr;

	// Read address translation, skips the header when present
	assign rom_raddr = has_hdr ?
		(rom_raddr_in + ROM_AW'(console_pkg::HEADER_BYTES)) & mask512 :
		rom_raddr_in & mask;

endmodule

`default_nettype wire

// ==== verilog/cheat_loader.sv ====
/*
 * Cheat-code assembler
 *   Collects 16-byte cheat records from the download stream
 *   Record valid and cheat list reset pulses
 */
`default_nettype none

module cheat_loader (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	input  wire                      ioctl_download,
	input  console_pkg::byte_t       ioctl_index,
	input  wire                      ioctl_wr,
	input  console_pkg::dl_addr_t    ioctl_addr,
	input  console_pkg::byte_t       ioctl_dout,
	output console_pkg::cheat_code_u cheat_code,
	output logic                     cheat_valid,
	output logic                     cheat_reset
);

	logic code_wr;
	logic last_byte;

	// Only downloads with the cheat index belong here
	assign code_wr   = ioctl_download && ioctl_wr &&
		(ioctl_index == console_pkg::CHEAT_INDEX);
	assign last_byte = &ioctl_addr[3:0];

	// ==========================================================
	// Record assembly
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code.b[ioctl_addr[3:0]] <= ioctl_dout;
	end

	// Pulses, one cycle after the triggering write
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= code_wr && last_byte;  // Record complete
			// Any download restarting at 0 drops the old cheat list
			cheat_reset <= ioctl_download && ioctl_wr && (ioctl_addr == '0);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/backup_seq.sv ====
/*
 * Backup-RAM sequencer
 *   Backup enable from the mounted save file
 *   Autosave pending flag
 *   Sector-by-sector load and save through the card interface
 */
`default_nettype none

module backup_seq #(
	parameter int SECTOR_BITS = 6
) (
	input  wire                clk_sys,
	input  wire                arst_n,
	input  wire                ioctl_download,
	input  console_pkg::byte_t ioctl_index,
	input  wire                img_mounted,
	input  wire                img_readonly,
	input  wire                img_size_nz,
	input  wire                osd_status,
	input  wire                autosave_en,
	input  wire                bk_load_req,
	input  wire                bk_save_req,
	input  wire                nvram_we,
	output logic [31:0]        sd_lba,
	output logic               sd_rd,
	output logic               sd_wr,
	input  wire                sd_ack,
	output logic               bk_busy,
	output logic               bk_loading,
	output logic               bk_pending
);

	logic                   cart_dl, cart_dl_q;
	logic                   bk_ena;
	logic                   save_req;
	logic                   load_q, save_q, ack_q;
	logic                   load_start, save_start, dl_end;
	logic [SECTOR_BITS-1:0] sector;

	assign cart_dl    = ioctl_download && (ioctl_index != console_pkg::CHEAT_INDEX);
	assign save_req   = bk_save_req || (bk_pending && osd_status && autosave_en);
	assign load_start = bk_load_req && bk_ena && !load_q;
	assign save_start = save_req && bk_ena && !save_q;
	assign dl_end     = cart_dl_q && !cart_dl && img_size_nz && bk_ena;
	assign sd_lba     = 32'(sector);

	// ==========================================================
	// Backup enable and pending flag
	// ==========================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_dl_q  <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl && !cart_dl_q)
				bk_ena <= 1'b0;
			// Save file is mounted by the end of the download
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
			if (bk_ena && !osd_status && nvram_we)
				bk_pending <= 1'b1;        // Game wrote its save RAM
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ==========================================================
	// Sector transfer
	// ==========================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sector     <= '0;
		end else begin
			load_q <= bk_load_req && bk_ena;
			save_q <= save_req && bk_ena;
			ack_q  <= sd_ack;
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;             // Request taken
				sd_wr <= 1'b0;
			end
			if (!bk_busy) begin
				if (load_start || save_start || dl_end) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_start || dl_end;  // Load wins a tie
					sector     <= '0;
					sd_rd      <= load_start || dl_end;
					sd_wr      <= !(load_start || dl_end);
				end
			end else if (ack_q && !sd_ack) begin
				if (&sector) begin
					bk_busy    <= 1'b0;    // Last sector done
					bk_loading <= 1'b0;
				end else begin
					sector <= sector + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/console_glue_top.sv ====
/*
 * Console housekeeping top level
 *   Clock enables, cartridge loader, cheat assembler, backup sequencer
 */
`default_nettype none

module console_glue_top #(
	parameter int ROM_AW      = 22,
	parameter int SECTOR_BITS = 6
) (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	// Clock enables
	output logic                     ce_cpu,
	output logic                     ce_vdp,
	output logic                     ce_pix,
	output logic                     ce_sp,
	// Download bus
	input  wire                      ioctl_download,
	input  console_pkg::byte_t       ioctl_index,
	input  wire                      ioctl_wr,
	input  console_pkg::dl_addr_t    ioctl_addr,
	input  console_pkg::byte_t       ioctl_dout,
	output logic                     ioctl_wait,
	// ROM memory
	output logic                     rom_wr,
	input  wire                      rom_wr_ack,
	output console_pkg::rom_addr_t   rom_waddr,
	output console_pkg::byte_t       rom_wdata,
	input  console_pkg::rom_addr_t   rom_raddr_in,
	output console_pkg::rom_addr_t   rom_raddr,
	output logic                     gg_mode,
	// Cheats
	output console_pkg::cheat_code_u cheat_code,
	output logic                     cheat_valid,
	output logic                     cheat_reset,
	// Backup RAM and card
	input  wire                      img_mounted,
	input  wire                      img_readonly,
	input  wire                      img_size_nz,
	input  wire                      osd_status,
	input  wire                      autosave_en,
	input  wire                      bk_load_req,
	input  wire                      bk_save_req,
	input  wire                      nvram_we,
	output logic [31:0]              sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	input  wire                      sd_ack,
	output logic                     bk_busy,
	output logic                     bk_loading,
	output logic                     bk_pending
);

	ce_divider u_ce (.clk_sys, .arst_n, .ce_cpu, .ce_vdp, .ce_pix, .ce_sp);

	cart_loader #(.ROM_AW(ROM_AW)) u_cart (
		.clk_sys, .arst_n,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.ioctl_wait, .rom_wr, .rom_wr_ack, .rom_waddr, .rom_wdata,
		.rom_raddr_in, .rom_raddr, .gg_mode
	);

	cheat_loader u_cheat (
		.clk_sys, .arst_n,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.cheat_code, .cheat_valid, .cheat_reset
	);

	// Backup sequencer sees only the download level and index
	backup_seq #(.SECTOR_BITS(SECTOR_BITS)) u_bk (
		.clk_sys, .arst_n,
		.ioctl_download, .ioctl_index,
		.img_mounted, .img_readonly, .img_size_nz, .osd_status, .autosave_en,
		.bk_load_req, .bk_save_req, .nvram_we,
		.sd_lba, .sd_rd, .sd_wr, .sd_ack,
		.bk_busy, .bk_loading, .bk_pending
	);

endmodule

`default_nettype wire

// ==== verification/console_glue_properties.sv ====
/*
 * Concurrent assertions on the console housekeeping top level
 *   Card read and write requests exclusive
 *   ROM write toggle only after acknowledge and without back-pressure
 *   Single-cycle cheat record pulse
 */
`default_nettype none

module console_glue_properties (
	input wire clk_sys,
	input wire arst_n,
	input wire sd_rd,
	input wire sd_wr,
	input wire rom_wr,
	input wire rom_wr_ack,
	input wire ioctl_wait,
	input wire cheat_valid
);

	a_sd_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	// A new ROM request only when the last one was acknowledged
	a_rom_toggle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(rom_wr != $past(rom_wr)) |->
			!$past(ioctl_wait) && ($past(rom_wr) == $past(rom_wr_ack)))
		else $error("rom_wr toggled before the previous write was acknowledged");

	a_cheat_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid longer than one cycle");

endmodule

bind console_glue_top console_glue_properties u_props (
	.clk_sys(clk_sys), .arst_n(arst_n), .sd_rd(sd_rd), .sd_wr(sd_wr),
	.rom_wr(rom_wr), .rom_wr_ack(rom_wr_ack), .ioctl_wait(ioctl_wait),
	.cheat_valid(cheat_valid)
);

`default_nettype wire

// ==== verification/tb_console_glue.sv ====
/*
 * Testbench of the console housekeeping top level
 *   Clock, reset, download driver, ROM memory and card models
 *   Reference functions for enables, read translation, cheats and sectors
 *   Typed compare tasks, error counts and watchdog
 */
`default_nettype none

module tb_console_glue;

	localparam int PLAN_CYCLES = 120 + 2600 * 7 + 80 + 3 * 64 * 9 + 200;

	logic clk_sys = 1'b0;
	logic arst_n;
	logic ce_cpu, ce_vdp, ce_pix, ce_sp;
	logic ioctl_download, ioctl_wr, ioctl_wait;
	console_pkg::byte_t ioctl_index, ioctl_dout, rom_wdata;
	console_pkg::dl_addr_t ioctl_addr;
	logic rom_wr, rom_wr_ack, gg_mode;
	console_pkg::rom_addr_t rom_waddr, rom_raddr_in, rom_raddr;
	console_pkg::cheat_code_u cheat_code;
	logic cheat_valid, cheat_reset;
	logic img_mounted, img_readonly, img_size_nz, osd_status, autosave_en;
	logic bk_load_req, bk_save_req, nvram_we, sd_rd, sd_wr, sd_ack;
	logic [31:0] sd_lba;
	logic bk_busy, bk_loading, bk_pending;

	integer seed = 32'h23cb851e;
	int err_val = 0;
	int err_misc = 0;
	int wcount;
	int n_valid, n_creset;
	console_pkg::byte_t dl_data [0:2047];
	console_pkg::byte_t mem [0:2047];
	logic [31:0] lba_q [$];
	bit dir_q [$];                     // 1 for a sector write

	console_glue_top #(.ROM_AW(22), .SECTOR_BITS(6)) u_dut (.*);

	always #5 clk_sys = ~clk_sys;

	// ==========================================================
	// Compare tasks
	// ==========================================================
	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			err_val++;
		end
	endtask

	task automatic check_rom_addr(input string name, input console_pkg::rom_addr_t exp,
			input console_pkg::rom_addr_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			err_val++;
		end
	endtask

	task automatic check_byte(input string name, input console_pkg::byte_t exp,
			input console_pkg::byte_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			err_val++;
		end
	endtask

	task automatic check_cheat(input string name, input console_pkg::cheat_code_u exp,
			input console_pkg::cheat_code_u act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			err_val++;
		end
	endtask

	task automatic check_lba(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			err_val++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			err_val++;
		end
	endtask

	// ==========================================================
	// Reference functions
	// ==========================================================
	// Enables k cycles after the first pixel pulse, which sits at phase 9
	function automatic logic [3:0] ref_ce(input int k);
		int ph;
		ph = (9 + k) % 30;
		return {ph == 9 || ph == 24, ph % 5 == 4, ph % 10 == 9, ph % 2 == 1};
	endfunction

	function automatic console_pkg::rom_addr_t ref_raddr(input int n,
			input console_pkg::rom_addr_t a);
		console_pkg::rom_addr_t m, m5;
		m  = '0;
		m5 = '0;
		for (int i = 0; i < n; i++) begin
			m  = (i == 0) ? '0 : m | console_pkg::rom_addr_t'(i);
			m5 = (i == 512) ? '0 : m5 | (console_pkg::rom_addr_t'(i) - 22'd512);
		end
		// Odd count of 512-byte blocks
		if ((n / console_pkg::HEADER_BYTES) % 2 == 1)
			return (a + 22'd512) & m5;   // Header present
		return a & m;
	endfunction

	// Little-endian field at a byte offset of the record
	function automatic logic [31:0] ref_word(input int o);
		return {dl_data[o+3], dl_data[o+2], dl_data[o+1], dl_data[o]};
	endfunction

	function automatic console_pkg::cheat_code_u ref_cheat();
		console_pkg::cheat_code_u c;
		c.rec.flags   = ref_word(0);
		c.rec.addr    = ref_word(4);
		c.rec.compare = ref_word(8);
		c.rec.replace = ref_word(12);
		return c;
	endfunction

	function automatic logic [31:0] ref_lba(input int i);
		return 32'(i % 64);              // Sectors in order from 0
	endfunction

	// ==========================================================
	// Memory and card models
	// ==========================================================
	initial begin
		rom_wr_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (rom_wr !== rom_wr_ack) begin
				check_rom_addr("rom_waddr", console_pkg::rom_addr_t'(wcount), rom_waddr);
				mem[rom_waddr[10:0]] = rom_wdata;
				wcount++;
				repeat (1 + $unsigned($random(seed)) % 4) @(posedge clk_sys);
				#1 rom_wr_ack = rom_wr;
			end
		end
	end

	initial begin
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (sd_rd || sd_wr) begin
				lba_q.push_back(sd_lba);
				dir_q.push_back(sd_wr);
				repeat (1 + $unsigned($random(seed)) % 3) @(posedge clk_sys);
				#1 sd_ack = 1'b1;
				repeat (1 + $unsigned($random(seed)) % 3) @(posedge clk_sys);
				#1 sd_ack = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (cheat_valid)
			n_valid++;
		if (cheat_reset)
			n_creset++;
	end

	// Watchdog
	initial begin
		repeat (20 * PLAN_CYCLES) @(posedge clk_sys);
		$display("Timeout, the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	// ==========================================================
	// Stimulus helpers
	// ==========================================================
	task automatic cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic download(input int n, input console_pkg::byte_t idx);
		int guard;
		wcount = 0;
		ioctl_index    = idx;
		ioctl_download = 1'b1;
		cycle();
		for (int i = 0; i < n; i++) begin
			guard = 0;
			while (ioctl_wait && guard < 50) begin
				cycle();
				guard++;
			end
			if (ioctl_wait) begin
				$display("Download stalled, ioctl_wait stuck high at byte %0d", i);
				err_misc++;
			end
			ioctl_addr = console_pkg::dl_addr_t'(i);
			ioctl_dout = dl_data[i];
			ioctl_wr   = 1'b1;
			cycle();
			ioctl_wr   = 1'b0;
			ioctl_addr = console_pkg::dl_addr_t'(i + 1);  // Host address moves past the byte
			if (idx != console_pkg::CHEAT_INDEX)
				check_bit("ioctl_wait", 1'b1, ioctl_wait);
		end
		while (ioctl_wait)
			cycle();
		ioctl_download = 1'b0;
		repeat (3) cycle();
	endtask

	task automatic pulse(ref logic sig);
		sig = 1'b1;
		cycle();
		sig = 1'b0;
	endtask

	// Waits for the end of a transfer, then checks the sector sequence
	task automatic sector_run(input string name, input bit wr);
		int guard;
		guard = 0;
		while (bk_busy && guard < 64 * 12) begin
			cycle();
			guard++;
		end
		if (bk_busy) begin
			$display("Transfer %s never finished", name);
			err_misc++;
		end
		check_count({name, " sectors"}, 64, lba_q.size());
		for (int i = 0; i < lba_q.size(); i++) begin
			check_lba({name, " lba"}, ref_lba(i), lba_q[i]);
			check_bit({name, " write"}, wr, dir_q[i]);
		end
		lba_q.delete();
		dir_q.delete();
	endtask

	// ==========================================================
	// Tests
	// ==========================================================
	initial begin
		logic [3:0] exp_ce;
		int cnt [4];
		int n_list [2];
		arst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		rom_raddr_in = '0;
		{img_mounted, img_readonly, img_size_nz, osd_status, autosave_en} = '0;
		{bk_load_req, bk_save_req, nvram_we} = '0;
		n_valid = 0;
		n_creset = 0;
		n_list = '{1536, 1024};
		repeat (2) @(posedge clk_sys);
		#1 arst_n = 1'b1;

		// Clock enables, 60 cycles from the first pixel pulse
		cnt = '{0, 0, 0, 0};
		for (int g = 0; g < 40 && !ce_pix; g++)
			@(negedge clk_sys);
		for (int k = 0; k < 60; k++) begin
			exp_ce = ref_ce(k);
			check_bit("ce_cpu", exp_ce[3], ce_cpu);
			check_bit("ce_vdp", exp_ce[2], ce_vdp);
			check_bit("ce_pix", exp_ce[1], ce_pix);
			check_bit("ce_sp", exp_ce[0], ce_sp);
			cnt[0] += ce_cpu;
			cnt[1] += ce_vdp;
			cnt[2] += ce_pix;
			cnt[3] += ce_sp;
			@(negedge clk_sys);
		end
		check_count("ce_cpu pulses", 4, cnt[0]);
		check_count("ce_vdp pulses", 12, cnt[1]);
		check_count("ce_pix pulses", 6, cnt[2]);
		check_count("ce_sp pulses", 30, cnt[3]);
		cycle();

		// Cartridge downloads with a header
		foreach (n_list[t]) begin
			for (int i = 0; i < 2048; i++)
				dl_data[i] = console_pkg::byte_t'($random(seed));
			download(n_list[t], t == 0 ? 8'h02 : 8'h01);
			for (int i = 0; i < n_list[t]; i++)
				check_byte("rom byte", dl_data[i], mem[i]);
			check_rom_addr("final rom_waddr", 22'(n_list[t]), rom_waddr);
			check_bit("gg_mode", t == 0, gg_mode);
			for (int r = 0; r < 20; r++) begin
				rom_raddr_in = console_pkg::rom_addr_t'($random(seed));
				@(negedge clk_sys);
				check_rom_addr("rom_raddr", ref_raddr(n_list[t], rom_raddr_in), rom_raddr);
				cycle();
			end
		end

		// Cheat record
		n_valid = 0;
		n_creset = 0;
		download(16, console_pkg::CHEAT_INDEX);
		check_count("cheat_valid pulses", 1, n_valid);
		check_count("cheat_reset pulses", 1, n_creset);
		check_cheat("cheat_code", ref_cheat(), cheat_code);

		// Backup load, enabled by a mounted writable save file
		{img_mounted, img_readonly, img_size_nz} = 3'b100;
		download(16, 8'h01);
		lba_q.delete();
		dir_q.delete();
		pulse(bk_load_req);
		cycle();
		check_bit("bk_loading", 1'b1, bk_loading);
		repeat (5) cycle();
		pulse(bk_load_req);               // Ignored while busy
		sector_run("load", 1'b0);
		repeat (10) cycle();
		check_bit("bk_busy idle", 1'b0, bk_busy);

		// Autosave after the menu opens
		pulse(nvram_we);
		cycle();
		check_bit("bk_pending set", 1'b1, bk_pending);
		autosave_en = 1'b1;
		osd_status  = 1'b1;
		repeat (2) cycle();
		sector_run("autosave", 1'b1);
		check_bit("bk_pending clear", 1'b0, bk_pending);
		osd_status = 1'b0;

		// Read-only image, nothing may start
		{img_readonly, img_size_nz} = 2'b11;
		download(4, 8'h01);
		pulse(nvram_we);
		cycle();
		check_bit("bk_pending disabled", 1'b0, bk_pending);
		osd_status = 1'b1;
		pulse(bk_load_req);
		pulse(bk_save_req);
		repeat (20) cycle();
		check_count("disabled sectors", 0, lba_q.size());
		check_bit("bk_busy disabled", 1'b0, bk_busy);

		$display("Errors: %0d wrong values, %0d other failures", err_val, err_misc);
		if (err_val + err_misc == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/console_pkg.sv
verilog/ce_divider.sv
verilog/cart_loader.sv
verilog/cheat_loader.sv
verilog/backup_seq.sv
verilog/console_glue_top.sv
verification/console_glue_properties.sv
verification/tb_console_glue.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_console_glue -f all.f -o tb_console_glue

./obj_dir/tb_console_glue | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	exit 0
fi
exit 1
